// File: nibbleRouter.f
rtl/routePkg.sv
rtl/syncFifo.sv
rtl/routeRegs.sv
rtl/laneAccum.sv
rtl/laneDiff.sv
rtl/laneMerge.sv
rtl/nibbleRouter.sv
tests/tbNibbleRouter.sv

// File: Makefile
# Verilator build and run for the nibble router testbench

VERILATOR ?= verilator
TOP ?= tbNibbleRouter
FILELIST ?= nibbleRouter.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_MSG ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Status comes from the search for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tbNibbleRouter.sv
module tbNibbleRouter;
	timeunit 1ns;
	timeprecision 1ps;
	import routePkg::*;

	typedef struct packed {
		mergeMode_t mode;
		nibble_t diffKey;
		logic accEnable;
		int itemCount;
		logic clearFirst;
		logic delayReads;	// Write all first, then drain
	} testRow_t;

	localparam int NumRows = 8;
	localparam int WaitLimit = 200;		// Cycles per wait
	localparam time DriveDelay = 1ns;
	localparam testRow_t Rows [NumRows] = '{
		'{ModeDiff, 4'h5, 1'b1, 10, 1'b0, 1'b0},	// Previous item starts at zero
		'{ModeAcc, 4'h0, 1'b1, 12, 1'b1, 1'b0},		// Sums from zero
		'{ModeAcc, 4'h0, 1'b0, 8, 1'b0, 1'b1},		// Pass through
		'{ModeAlt, 4'h3, 1'b1, 11, 1'b0, 1'b0},
		'{ModeXor, 4'h9, 1'b1, 9, 1'b1, 1'b0},
		'{ModeDiff, 4'hc, 1'b1, 24, 1'b0, 1'b1},	// Back-pressure
		'{ModeAcc, 4'h0, 1'b1, 6, 1'b1, 1'b0},		// Restart after clear
		'{ModeAlt, 4'h7, 1'b0, 24, 1'b1, 1'b1}
	};

	logic inClock = 1'b0;
	logic arstN;
	nibble_t inData;
	logic inWrite;
	logic inFull;
	nibble_t outData;
	logic outRead;
	logic outEmpty;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	wbAddr_t wbAdr;
	wbData_t wbDatW;
	wbData_t wbDatR;
	logic wbAck;

	// Reference model state
	nibble_t sumM;
	nibble_t prevM;
	nibble_t keyM;
	logic enM;
	logic turnM;
	mergeMode_t modeM;
	nibble_t expQ [$];			// Predicted outputs in order
	logic [7:0] lfsr = 8'd48;
	int passCount;
	int failCount;
	bit aborted;

	nibbleRouter DUT (.*);

	always #4 inClock = ~inClock;	// 8 ns period

	//////////////////////////////////////////////////////////////////////
	// Stimulus and model
	//////////////////////////////////////////////////////////////////////
	function automatic logic [7:0] lfsrNext(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};	// Taps 8,6,5,4
	endfunction

	task automatic drawNibble(output nibble_t n);
		n = '0;
		repeat (4) begin
			n = {n[2:0], lfsr[7]};	// One step per bit
			lfsr = lfsrNext(lfsr);
		end
	endtask

	task automatic predictItem(input nibble_t item);
		nibble_t accR;
		nibble_t diffR;
		if (enM) begin
			sumM = sumM + item;
			accR = sumM;
		end else accR = item;		// Lane bypass
		diffR = item ^ prevM ^ keyM;
		prevM = item;
		case (modeM)
			ModeAcc: expQ.push_back(accR);
			ModeDiff: expQ.push_back(diffR);
			ModeAlt: begin
				expQ.push_back(turnM ? diffR : accR);
				turnM = !turnM;
			end
			default: expQ.push_back(accR ^ diffR);
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////
	task automatic checkNibble(input string name, input nibble_t expected, input nibble_t actual);
		if (expected !== actual) begin
			$display("error at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
			failCount++;
		end else passCount++;
	endtask

	task automatic checkWord(input string name, input wbData_t expected, input wbData_t actual);
		if (expected !== actual) begin
			$display("error at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
			failCount++;
		end else passCount++;
	endtask

	task automatic timedOut(input string what);
		$display("Timed out at %0d ns waiting for %s", $time, what);
		failCount++;
		aborted = 1'b1;				// Stop all further waits
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus and data tasks, all start and end 1 ns after an edge
	//////////////////////////////////////////////////////////////////////
	task automatic wbAccess(input logic we, input wbAddr_t addr, input wbData_t wdata,
			output wbData_t rdata);
		int cycles;
		cycles = 0;
		rdata = '0;
		if (aborted) return;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = addr;
		wbDatW = wdata;
		do begin
			@(posedge inClock);
			#DriveDelay;
			cycles++;
		end while (!wbAck && cycles < WaitLimit);
		if (wbAck) rdata = wbDatR;
		else timedOut("wbAck");
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic setConfig(input mergeMode_t mode, input nibble_t key, input logic en);
		wbData_t unused;
		wbAccess(1'b1, CfgAddr, {7'b0, en, key, 2'b0, mode}, unused);
		if (mode != modeM) turnM = 1'b0;	// Alternation restarts on accumulator
		modeM = mode;
		keyM = key;
		enM = en;
	endtask

	task automatic writeItem(input bit stopOnFull, output bit accepted);
		nibble_t item;
		int cycles;
		cycles = 0;
		accepted = 1'b0;
		while (inFull && !stopOnFull && !aborted && cycles < WaitLimit) begin
			@(posedge inClock);
			#DriveDelay;
			cycles++;
		end
		if (aborted) return;
		if (inFull) begin
			if (!stopOnFull) timedOut("inFull to fall");
			return;
		end
		drawNibble(item);
		predictItem(item);
		inData = item;
		inWrite = 1'b1;
		@(posedge inClock);
		#DriveDelay;
		inWrite = 1'b0;
		accepted = 1'b1;
	endtask

	task automatic readItem();
		int cycles;
		cycles = 0;
		while (outEmpty && !aborted && cycles < WaitLimit) begin
			@(posedge inClock);
			#DriveDelay;
			cycles++;
		end
		if (aborted) return;
		if (outEmpty) begin
			timedOut("outEmpty to fall");
			return;
		end
		if (expQ.size() == 0) begin
			$display("Output item at %0d ns has no matching input", $time);
			failCount++;
			aborted = 1'b1;
			return;
		end
		checkNibble("outData", expQ.pop_front(), outData);	// Head is stable here
		outRead = 1'b1;
		@(posedge inClock);
		#DriveDelay;
		outRead = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		testRow_t row;
		wbData_t word;
		int accepted;
		int failsBefore;
		int wi;
		int ri;
		bit ok;
		bit okW;
		arstN = 1'b0;
		inData = '0;
		inWrite = 1'b0;
		outRead = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		sumM = '0;
		prevM = '0;
		keyM = '0;
		enM = 1'b0;
		turnM = 1'b0;
		modeM = ModeAcc;
		passCount = 0;
		failCount = 0;
		aborted = 1'b0;
		repeat (2) @(posedge inClock);
		#DriveDelay;
		arstN = 1'b1;

		// Register map
		wbAccess(1'b0, StatusAddr, '0, word);
		checkWord("status", '0, word);		// Idle counts
		setConfig(ModeXor, 4'ha, 1'b1);
		wbAccess(1'b0, CfgAddr, '0, word);
		checkWord("cfg", 16'h01a3, word);
		wbAccess(1'b1, 2'd3, 16'hffff, word);	// Unmapped write ignored
		wbAccess(1'b0, CfgAddr, '0, word);
		checkWord("cfg", 16'h01a3, word);
		wbAccess(1'b0, 2'd3, '0, word);
		checkWord("unmapped", '0, word);
		wbAccess(1'b0, CmdAddr, '0, word);
		checkWord("cmd", '0, word);
		$display("register access: %s", (failCount == 0) ? "ok" : "FAILED");

		for (int r = 0; r < NumRows && !aborted; r++) begin
			row = Rows[r];
			failsBefore = failCount;
			if (row.clearFirst) begin
				wbAccess(1'b1, CmdAddr, 16'h0001, word);
				sumM = '0;		// Previous item survives the clear
			end
			setConfig(row.mode, row.diffKey, row.accEnable);
			accepted = 0;
			if (row.delayReads) begin
				for (wi = 0; wi < row.itemCount && !aborted; wi++) begin
					writeItem(1'b1, ok);
					if (!ok) break;
					accepted++;
				end
				if (row.itemCount > InDepth + OutDepth + 2 && !aborted) begin
					// Both FIFOs full plus two items in flight
					if (accepted != InDepth + OutDepth + 2) begin
						$display("Input accepted %0d items instead of %0d before stalling",
							accepted, InDepth + OutDepth + 2);
						failCount++;
					end
					wbAccess(1'b0, StatusAddr, '0, word);
					checkWord("status", {3'b0, fillCount_t'(OutDepth), 3'b0,
						fillCount_t'(InDepth)}, word);
				end
				for (ri = 0; ri < accepted; ri++) readItem();
			end else begin
				accepted = row.itemCount;
				fork
					begin
						for (wi = 0; wi < row.itemCount; wi++) begin
							writeItem(1'b0, okW);
							if (!okW) break;
						end
					end
					begin
						for (ri = 0; ri < row.itemCount; ri++) readItem();
					end
				join
			end
			wbAccess(1'b0, StatusAddr, '0, word);
			checkWord("status", '0, word);	// Nothing left over
			$display("row %0d mode %0d items %0d: %s", r, row.mode, accepted,
				(failCount == failsBefore) ? "ok" : "FAILED");
		end

		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: rtl/nibbleRouter.sv
module nibbleRouter (
	input  logic              inClock,
	input  logic              arstN,
	input  routePkg::nibble_t inData,
	input  logic              inWrite,
	output logic              inFull,
	output routePkg::nibble_t outData,
	input  logic              outRead,
	output logic              outEmpty,
	input  logic              wbCyc,
	input  logic              wbStb,
	input  logic              wbWe,
	input  routePkg::wbAddr_t wbAdr,
	input  routePkg::wbData_t wbDatW,
	output routePkg::wbData_t wbDatR,
	output logic              wbAck
);
	import routePkg::*;

	routeCfg_t cfg;
	routeStatus_t status;
	logic accClear;
	logic advance;			// Pipeline stall enable
	logic outFull;
	logic inEmpty;
	nibble_t headItem;		// Fanned out to both lanes
	nibble_t accResult;
	nibble_t diffResult;
	nibble_t merged;
	logic accValid;
	logic diffValid;
	logic mergeValid;

	//////////////////////////////////////////////////////////////////////
	// Stall wiring
	//////////////////////////////////////////////////////////////////////
	assign advance = !outFull;

	syncFifo #(.Depth(InDepth)) inFifo (
		.inClock(inClock), .arstN(arstN),
		.wrData(inData), .wrEn(inWrite), .full(inFull),
		.rdData(headItem), .rdEn(advance), .empty(inEmpty),
		.count(status.inCount)
	);

	laneAccum accLane (
		.inClock(inClock), .arstN(arstN), .advance(advance),
		.inValid(!inEmpty), .inItem(headItem),
		.accEnable(cfg.accEnable), .accClear(accClear),
		.result(accResult), .outValid(accValid)
	);

	laneDiff diffLane (
		.inClock(inClock), .arstN(arstN), .advance(advance),
		.inValid(!inEmpty), .inItem(headItem), .diffKey(cfg.diffKey),
		.result(diffResult), .outValid(diffValid)
	);

	laneMerge merge (
		.inClock(inClock), .arstN(arstN), .advance(advance),
		.inValid(accValid && diffValid),	// Lanes move in lockstep
		.accResult(accResult), .diffResult(diffResult), .mode(cfg.mode),
		.merged(merged), .outValid(mergeValid)
	);

	syncFifo #(.Depth(OutDepth)) outFifo (
		.inClock(inClock), .arstN(arstN),
		.wrData(merged), .wrEn(mergeValid && advance), .full(outFull),
		.rdData(outData), .rdEn(outRead), .empty(outEmpty),
		.count(status.outCount)
	);

	routeRegs regs (
		.inClock(inClock), .arstN(arstN),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.cfg(cfg), .status(status), .accClear(accClear)
	);

endmodule

// File: rtl/laneMerge.sv
module laneMerge (
	input  logic                 inClock,
	input  logic                 arstN,
	input  logic                 advance,
	input  logic                 inValid,
	input  routePkg::nibble_t    accResult,
	input  routePkg::nibble_t    diffResult,
	input  routePkg::mergeMode_t mode,
	output routePkg::nibble_t    merged,
	output logic                 outValid
);
	import routePkg::*;

	logic turn;			// 0 picks accumulator
	mergeMode_t modeQ;	// Last mode, for change detect
	nibble_t pick;
	logic take;

	assign take = advance && inValid;

	always_comb begin
		case (mode)
			ModeAcc: pick = accResult;
			ModeDiff: pick = diffResult;
			ModeAlt: pick = turn ? diffResult : accResult;
			default: pick = accResult ^ diffResult;	// ModeXor
		endcase
	end

	always_ff @(posedge inClock or negedge arstN) begin
		if (!arstN) begin
			turn <= 1'b0;
			modeQ <= '0;
			outValid <= 1'b0;
		end else begin
			modeQ <= mode;
			if (mode != modeQ) turn <= 1'b0;	// Restart on accumulator
			else if (take && (mode == ModeAlt)) turn <= !turn;
			if (advance) outValid <= inValid;
		end
	end

	always_ff @(posedge inClock) begin
		if (take) merged <= pick;
	end

endmodule

// File: rtl/laneDiff.sv
module laneDiff (
	input  logic              inClock,
	input  logic              arstN,
	input  logic              advance,
	input  logic              inValid,
	input  routePkg::nibble_t inItem,
	input  routePkg::nibble_t diffKey,
	output routePkg::nibble_t result,
	output logic              outValid
);
	import routePkg::*;

	nibble_t prevItem;		// Last valid item, zero after reset
	logic take;

	assign take = advance && inValid;

	always_ff @(posedge inClock or negedge arstN) begin
		if (!arstN) begin
			prevItem <= '0;
			outValid <= 1'b0;
		end else begin
			if (take) prevItem <= inItem;
			if (advance) outValid <= inValid;
		end
	end

	// Item, previous and key combined
	always_ff @(posedge inClock) begin
		if (take) result <= inItem ^ prevItem ^ diffKey;
	end

endmodule

// File: rtl/laneAccum.sv
module laneAccum (
	input  logic              inClock,
	input  logic              arstN,
	input  logic              advance,
	input  logic              inValid,
	input  routePkg::nibble_t inItem,
	input  logic              accEnable,
	input  logic              accClear,
	output routePkg::nibble_t result,
	output logic              outValid
);
	import routePkg::*;

	nibble_t sum;
	nibble_t nextSum;
	logic take;

	assign take = advance && inValid;
	assign nextSum = sum + inItem;	// Wraps modulo 16

	// Running sum, clear wins over update
	always_ff @(posedge inClock or negedge arstN) begin
		if (!arstN) begin
			sum <= '0;
			outValid <= 1'b0;
		end else begin
			if (accClear) sum <= '0;
			else if (take && accEnable) sum <= nextSum;
			if (advance) outValid <= inValid;	// Hold on stall
		end
	end

	always_ff @(posedge inClock) begin
		if (take) result <= accEnable ? nextSum : inItem;	// Bypass when off
	end

endmodule

// File: rtl/routeRegs.sv
module routeRegs (
	input  logic                  inClock,
	input  logic                  arstN,
	input  logic                  wbCyc,
	input  logic                  wbStb,
	input  logic                  wbWe,
	input  routePkg::wbAddr_t     wbAdr,
	input  routePkg::wbData_t     wbDatW,
	output routePkg::wbData_t     wbDatR,
	output logic                  wbAck,
	output routePkg::routeCfg_t   cfg,
	input  routePkg::routeStatus_t status,
	output logic                  accClear
);
	import routePkg::*;

	logic req;			// New cycle, not yet acked
	logic wrReq;
	wbData_t rdMux;

	assign req = wbCyc && wbStb && !wbAck;
	assign wrReq = req && wbWe;

	//////////////////////////////////////////////////////////////////////
	// Read data
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		rdMux = '0;			// Unmapped and command read zero
		case (wbAdr)
			CfgAddr: begin
				rdMux[1:0] = cfg.mode;
				rdMux[7:4] = cfg.diffKey;
				rdMux[8] = cfg.accEnable;
			end
			StatusAddr: begin
				rdMux[4:0] = status.inCount;
				rdMux[12:8] = status.outCount;
			end
			default: rdMux = '0;
		endcase
	end

	// Sampled on the edge that raises ack
	always_ff @(posedge inClock) begin
		if (req) wbDatR <= rdMux;
	end

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge inClock or negedge arstN) begin
		if (!arstN) begin
			wbAck <= 1'b0;
			cfg <= '0;
			accClear <= 1'b0;
		end else begin
			wbAck <= req;		// One cycle per access
			accClear <= wrReq && (wbAdr == CmdAddr) && wbDatW[0];
			if (wrReq && (wbAdr == CfgAddr)) begin
				cfg.mode <= wbDatW[1:0];
				cfg.diffKey <= wbDatW[7:4];
				cfg.accEnable <= wbDatW[8];
			end
		end
	end

endmodule

// File: rtl/syncFifo.sv
module syncFifo #(
	parameter int Depth = routePkg::InDepth
) (
	input  logic               inClock,
	input  logic               arstN,
	input  routePkg::nibble_t  wrData,
	input  logic               wrEn,
	output logic               full,
	output routePkg::nibble_t  rdData,
	input  logic               rdEn,
	output logic               empty,
	output routePkg::fillCount_t count
);
	import routePkg::*;

	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

	nibble_t mem [Depth];			// Storage, no reset
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic doWrite;
	logic doRead;

	assign full = (count == fillCount_t'(Depth));
	assign empty = (count == '0);
	assign doWrite = wrEn && !full;	// Drop writes when full
	assign doRead = rdEn && !empty;	// Ignore reads when empty
	assign rdData = mem[rdPtr];		// Head shows through

	always_ff @(posedge inClock) begin
		if (doWrite) mem[wrPtr] <= wrData;
	end

	always_ff @(posedge inClock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite) begin
				// Wrap at Depth, not only powers of two
				wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doRead) begin
				rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			end
			if (doWrite && !doRead) count <= count + 1'b1;
			else if (doRead && !doWrite) count <= count - 1'b1;
			// Push with pop keeps count
		end
	end

endmodule

// File: rtl/routePkg.sv
package routePkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////
	localparam int NibbleW = 4;		// One data item
	localparam int FillW = 5;		// Occupancy, depth up to 16
	localparam int WbAddrW = 2;		// Word address
	localparam int WbDataW = 16;

	typedef logic [NibbleW-1:0] nibble_t;
	typedef logic [1:0] mergeMode_t;
	typedef logic [FillW-1:0] fillCount_t;
	typedef logic [WbAddrW-1:0] wbAddr_t;
	typedef logic [WbDataW-1:0] wbData_t;

	// Merge mode codes
	localparam mergeMode_t ModeAcc = 2'd0;	// Accumulating lane only
	localparam mergeMode_t ModeDiff = 2'd1;	// Differencing lane only
	localparam mergeMode_t ModeAlt = 2'd2;	// Alternate, accumulator first
	localparam mergeMode_t ModeXor = 2'd3;	// Both lanes xored

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		mergeMode_t mode;
		nibble_t diffKey;
		logic accEnable;	// Low holds the sum, lane passes items
	} routeCfg_t;

	typedef struct packed {
		fillCount_t inCount;
		fillCount_t outCount;
	} routeStatus_t;

	localparam wbAddr_t CfgAddr = 2'd0;		// mode 1..0, key 7..4, enable 8
	localparam wbAddr_t StatusAddr = 2'd1;	// inCount 4..0, outCount 12..8
	localparam wbAddr_t CmdAddr = 2'd2;		// Bit 0 clears accumulator

	// FIFO depths
	localparam int InDepth = 8;
	localparam int OutDepth = 8;

endpackage
